// ==== design/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // geometry of the 16 KB two-way cache
    localparam int words_per_line = 16;
    localparam int num_ways       = 2;
    localparam int num_sets       = 128;
    localparam int byte_per_word  = 4;
    localparam int offset_bits    = 4;
    localparam int index_bits     = 7;
    localparam int align_bits     = 2;
    localparam int tag_bits       = 32 - index_bits - offset_bits - align_bits;

    typedef logic [8*byte_per_word-1:0] word_t;
    typedef logic [byte_per_word-1:0]   strobe_t;
    typedef logic [tag_bits-1:0]        tag_t;
    typedef logic [index_bits-1:0]      index_t;
    typedef logic [offset_bits-1:0]     offset_t;
    typedef logic                       way_t;

    typedef struct packed {
        tag_t                  tag;
        index_t                index;
        offset_t               offset;
        logic [align_bits-1:0] align;
    } addr_t;

    // one word location in the data array
    typedef struct packed {
        way_t    way;
        index_t  index;
        offset_t offset;
    } ram_addr_t;

    // zero strobe means a read
    typedef struct packed {
        logic    valid;
        logic    uncached;
        addr_t   addr;
        strobe_t strobe;
        word_t   data;
    } dreq_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t data;
    } dresp_t;

    // len is beats minus one
    typedef struct packed {
        logic                   valid;
        logic                   is_write;
        addr_t                  addr;
        strobe_t                strobe;
        word_t                  data;
        logic [offset_bits-1:0] len;
    } cbus_req_t;

    typedef struct packed {
        logic  ready;
        logic  last;
        word_t data;
    } cbus_resp_t;

    typedef enum logic [1:0] {
        idle,
        writeback,
        refill,
        uncached
    } miss_state_t;

    // replace the strobed bytes of old_word with those of new_word
    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                          input strobe_t strobe);
        word_t merged;
        merged = old_word;
        for (int b = 0; b < byte_per_word; b++) begin
            if (strobe[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

`default_nettype wire

// ==== design/dcache_beat_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_beat_counter
    import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    load,
    input  offset_t start,
    input  logic    step,
    output offset_t offset,
    output offset_t next_offset,
    output logic    wrapped
);
    offset_t steps;

    // offsets wrap within the line
    assign next_offset = offset + offset_t'(1);
    assign wrapped     = step & (&steps);

    always_ff @(posedge clk) begin
        if (resetn) begin
            offset <= '0;
            steps  <= '0;
        end else if (load) begin
            offset <= start;
            steps  <= '0;
        end else if (step) begin
            offset <= next_offset;
            steps  <= steps + offset_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== design/dcache_data_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_data_array
    import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      en1,
    input  ram_addr_t addr1,
    input  strobe_t   strobe1,
    input  word_t     wdata1,
    input  logic      en2,
    input  ram_addr_t addr2,
    input  strobe_t   strobe2,
    input  word_t     wdata2,
    output word_t     rdata1,
    output word_t     rdata2
);
    word_t mem [num_ways*num_sets*words_per_line];

    // reads return the old word, one cycle later
    always_ff @(posedge clk) begin
        if (en1) begin
            rdata1 <= mem[addr1];
            if (|strobe1) begin
                mem[addr1] <= merge_bytes(mem[addr1], wdata1, strobe1);
            end
        end
        // lookup and miss traffic never touch the same word in a cycle
        if (en2) begin
            rdata2 <= mem[addr2];
            if (|strobe2) begin
                mem[addr2] <= merge_bytes(mem[addr2], wdata2, strobe2);
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/dcache_tag_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_tag_store
    import dcache_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    input  index_t lookup_index,
    input  tag_t   lookup_tag,
    input  index_t upd_index,
    input  logic   hit_write,
    input  way_t   hit_way,
    input  logic   refill_done,
    input  tag_t   refill_tag,
    input  logic   refill_dirty,
    output logic   hit,
    output way_t   hit_way_out,
    output way_t   victim_way,
    output tag_t   victim_tag,
    output logic   victim_dirty,
    output logic   sweep_busy
);
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } meta_t;

    meta_t               meta [num_ways][num_sets];
    way_t                lru [num_sets];
    index_t              sweep_index;
    logic [num_ways-1:0] hit_bits;
    meta_t               victim_meta;

    // clear one set per cycle after reset
    always_ff @(posedge clk) begin
        if (resetn) begin
            sweep_busy  <= 1'b1;
            sweep_index <= '0;
        end else if (sweep_busy) begin
            sweep_index <= sweep_index + index_t'(1);
            if (&sweep_index) begin
                sweep_busy <= 1'b0;
            end
        end
    end

    always_comb begin
        hit_way_out = '0;
        for (int w = 0; w < num_ways; w++) begin
            hit_bits[w] = meta[w][lookup_index].valid && meta[w][lookup_index].tag == lookup_tag;
            if (hit_bits[w]) begin
                hit_way_out = way_t'(w);
            end
        end
    end

    assign hit = |hit_bits;

    // lru bit names the way to replace next
    assign victim_way   = lru[upd_index];
    assign victim_meta  = meta[victim_way][upd_index];
    assign victim_tag   = victim_meta.tag;
    assign victim_dirty = victim_meta.valid & victim_meta.dirty;

    always_ff @(posedge clk) begin
        if (sweep_busy) begin
            for (int w = 0; w < num_ways; w++) begin
                meta[w][sweep_index] <= '0;
            end
            lru[sweep_index] <= '0;
        end else if (refill_done) begin
            meta[victim_way][upd_index] <= '{valid: 1'b1, dirty: refill_dirty, tag: refill_tag};
            lru[upd_index]              <= ~victim_way;
        end else if (hit_write) begin
            if (refill_dirty) begin
                meta[hit_way][upd_index].dirty <= 1'b1;
            end
            lru[upd_index] <= ~hit_way;
        end
    end

endmodule

`default_nettype wire

// ==== design/dcache_miss_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_miss_ctrl
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       start,
    input  dreq_t      req,
    input  way_t       victim_way,
    input  tag_t       victim_tag,
    input  logic       victim_dirty,
    input  offset_t    offset,
    input  offset_t    next_offset,
    input  word_t      rdata2,
    input  cbus_resp_t cbus_resp,
    output cbus_req_t  cbus_req,
    output logic       cnt_load,
    output logic       cnt_step,
    output logic       en2,
    output ram_addr_t  addr2,
    output strobe_t    strobe2,
    output word_t      wdata2,
    output logic       refill_done,
    output word_t      uncached_data,
    output logic       done
);
    miss_state_t state;
    logic        primed;
    logic        beat;
    logic        last_beat;

    assign beat      = cbus_req.valid & cbus_resp.ready;
    assign last_beat = beat & cbus_resp.last;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state  <= idle;
            primed <= 1'b0;
        end else begin
            // first write-back cycle only fetches the first word
            primed <= (state == writeback);
            case (state)
                idle: begin
                    if (start) begin
                        if (req.uncached) begin
                            state <= uncached;
                        end else if (victim_dirty) begin
                            state <= writeback;
                        end else begin
                            state <= refill;
                        end
                    end
                end
                writeback: begin
                    if (last_beat) begin
                        state <= refill;
                    end
                end
                default: begin
                    if (last_beat) begin
                        state <= idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == uncached && beat) begin
            uncached_data <= cbus_resp.data;
        end
    end

    assign cnt_load    = (state == idle) & start;
    assign cnt_step    = beat & (state == writeback || state == refill);
    assign refill_done = last_beat & (state == refill);
    assign done        = last_beat & (state == refill || state == uncached);

    // bursts start at the critical word and wrap
    always_comb begin
        cbus_req            = '0;
        cbus_req.addr       = req.addr;
        cbus_req.addr.align = '0;
        cbus_req.strobe     = '1;
        cbus_req.len        = offset_bits'(words_per_line - 1);
        case (state)
            writeback: begin
                cbus_req.valid    = primed;
                cbus_req.is_write = 1'b1;
                cbus_req.addr.tag = victim_tag;
                cbus_req.data     = rdata2;
            end
            refill: begin
                cbus_req.valid = 1'b1;
            end
            uncached: begin
                cbus_req.valid    = 1'b1;
                cbus_req.is_write = |req.strobe;
                cbus_req.addr     = req.addr;
                cbus_req.strobe   = req.strobe;
                cbus_req.data     = req.data;
                cbus_req.len      = '0;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        en2          = 1'b0;
        strobe2      = '0;
        addr2.way    = victim_way;
        addr2.index  = req.addr.index;
        addr2.offset = offset;
        wdata2       = cbus_resp.data;
        if (state == writeback) begin
            // read ahead once the current beat is taken
            en2 = 1'b1;
            if (beat) begin
                addr2.offset = next_offset;
            end
        end else if (state == refill) begin
            en2     = beat;
            strobe2 = '1;
            if (offset == req.addr.offset) begin
                wdata2 = merge_bytes(cbus_resp.data, req.data, req.strobe);
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/dcache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_top
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  dreq_t      dreq,
    input  cbus_resp_t cbus_resp,
    output dresp_t     dresp,
    output cbus_req_t  cbus_req
);
    dreq_t     lk_req;
    logic      lk_valid;
    logic      lk_hit;
    way_t      lk_way;
    logic      miss_pending;
    logic      resp_uncached;
    logic      data_ok_q;
    logic      accept;
    logic      hit_accept;
    logic      fill_read;
    logic      hit;
    way_t      lookup_way;
    way_t      victim_way;
    tag_t      victim_tag;
    logic      victim_dirty;
    logic      sweep_busy;
    logic      en1;
    ram_addr_t addr1;
    strobe_t   strobe1;
    word_t     rdata1;
    logic      en2;
    ram_addr_t addr2;
    strobe_t   strobe2;
    word_t     wdata2;
    word_t     rdata2;
    logic      cnt_load;
    logic      cnt_step;
    logic      wrapped;
    offset_t   offset;
    offset_t   next_offset;
    logic      refill_done;
    logic      done;
    word_t     uncached_data;

    assign dresp = '{
        addr_ok: ~sweep_busy & ~miss_pending,
        data_ok: data_ok_q,
        data:    resp_uncached ? uncached_data : rdata1
    };
    assign accept        = dreq.valid & dresp.addr_ok;
    assign hit_accept    = accept & hit & ~dreq.uncached;

    // lookup register holds a miss until it completes
    always_ff @(posedge clk) begin
        if (accept) begin
            lk_req <= dreq;
            lk_hit <= hit & ~dreq.uncached;
            lk_way <= lookup_way;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            lk_valid      <= 1'b0;
            miss_pending  <= 1'b0;
            data_ok_q     <= 1'b0;
            resp_uncached <= 1'b0;
        end else begin
            lk_valid      <= accept;
            data_ok_q     <= hit_accept | done;
            resp_uncached <= done & lk_req.uncached;
            if (accept && !(hit && !dreq.uncached)) begin
                miss_pending <= 1'b1;
            end else if (done) begin
                miss_pending <= 1'b0;
            end
        end
    end

    // re-read the critical word once the line is back in place
    assign fill_read = refill_done & wrapped;

    assign en1     = hit_accept | fill_read;
    assign addr1   = fill_read ? {victim_way, lk_req.addr.index, lk_req.addr.offset}
                               : {lookup_way, dreq.addr.index, dreq.addr.offset};
    assign strobe1 = hit_accept ? dreq.strobe : '0;

    dcache_tag_store tag_store_i (
        .clk          (clk),
        .resetn       (resetn),
        .lookup_index (dreq.addr.index),
        .lookup_tag   (dreq.addr.tag),
        .upd_index    (lk_req.addr.index),
        .hit_write    (lk_valid & lk_hit),
        .hit_way      (lk_way),
        .refill_done  (refill_done),
        .refill_tag   (lk_req.addr.tag),
        .refill_dirty (|lk_req.strobe),
        .hit          (hit),
        .hit_way_out  (lookup_way),
        .victim_way   (victim_way),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty),
        .sweep_busy   (sweep_busy)
    );

    dcache_data_array data_array_i (
        .clk     (clk),
        .en1     (en1),
        .addr1   (addr1),
        .strobe1 (strobe1),
        .wdata1  (dreq.data),
        .en2     (en2),
        .addr2   (addr2),
        .strobe2 (strobe2),
        .wdata2  (wdata2),
        .rdata1  (rdata1),
        .rdata2  (rdata2)
    );

    dcache_miss_ctrl miss_ctrl_i (
        .clk           (clk),
        .resetn        (resetn),
        .start         (lk_valid & ~lk_hit),
        .req           (lk_req),
        .victim_way    (victim_way),
        .victim_tag    (victim_tag),
        .victim_dirty  (victim_dirty),
        .offset        (offset),
        .next_offset   (next_offset),
        .rdata2        (rdata2),
        .cbus_resp     (cbus_resp),
        .cbus_req      (cbus_req),
        .cnt_load      (cnt_load),
        .cnt_step      (cnt_step),
        .en2           (en2),
        .addr2         (addr2),
        .strobe2       (strobe2),
        .wdata2        (wdata2),
        .refill_done   (refill_done),
        .uncached_data (uncached_data),
        .done          (done)
    );

    dcache_beat_counter beat_counter_i (
        .clk         (clk),
        .resetn      (resetn),
        .load        (cnt_load),
        .start       (lk_req.addr.offset),
        .step        (cnt_step),
        .offset      (offset),
        .next_offset (next_offset),
        .wrapped     (wrapped)
    );

endmodule

`default_nettype wire

// ==== test/dcache_mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_mem_model
    import dcache_pkg::*;
(
    input  logic       clk,
    input  cbus_req_t  cbus_req,
    output cbus_resp_t cbus_resp
);
    localparam int mem_words = 16384;
    localparam int log_depth = 1024;

    word_t   mem [mem_words];
    int      beat_cnt;
    int      read_bursts;
    int      write_bursts;
    int      single_reads;
    int      single_writes;
    int      log_count;
    int      log_addr [log_depth];
    word_t   log_data [log_depth];
    int      last_single_addr;
    strobe_t last_single_strobe;
    word_t   last_single_data;

    // bursts wrap inside the line from the critical word
    function automatic int beat_word(input cbus_req_t r, input int n);
        logic [31:0] a;
        a = r.addr;
        if (r.len == 0) begin
            return int'(a[15:2]);
        end
        return int'({a[15:6], 4'(a[5:2] + n)});
    endfunction

    initial begin
        cbus_resp     = '0;
        beat_cnt      = 0;
        read_bursts   = 0;
        write_bursts  = 0;
        single_reads  = 0;
        single_writes = 0;
        log_count     = 0;
    end

    // request is stable here, so the beat is decided and done at the falling edge
    always @(negedge clk) begin
        int w;
        cbus_resp = '0;
        if (cbus_req.valid && $urandom_range(3) != 0) begin
            w                = beat_word(cbus_req, beat_cnt);
            cbus_resp.ready  = 1'b1;
            cbus_resp.last   = (beat_cnt == int'(cbus_req.len));
            cbus_resp.data   = mem[w];
            if (cbus_req.is_write) begin
                mem[w] = merge_bytes(mem[w], cbus_req.data, cbus_req.strobe);
                if (cbus_req.len != 0 && log_count < log_depth) begin
                    log_addr[log_count] = w;
                    log_data[log_count] = cbus_req.data;
                    log_count++;
                end else if (cbus_req.len == 0) begin
                    last_single_addr   = w;
                    last_single_strobe = cbus_req.strobe;
                    last_single_data   = cbus_req.data;
                end
            end
            if (cbus_resp.last) begin
                beat_cnt = 0;
                if (cbus_req.len == 0) begin
                    if (cbus_req.is_write) single_writes++;
                    else single_reads++;
                end else if (cbus_req.is_write) begin
                    write_bursts++;
                end else begin
                    read_bursts++;
                end
            end else begin
                beat_cnt++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/dcache_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
;
    localparam int mem_words    = 16384;
    localparam int num_requests = 44;
    localparam int watch_cycles = 200 + 40 * num_requests;

    logic       clk;
    logic       resetn;
    dreq_t      dreq;
    dresp_t     dresp;
    cbus_req_t  cbus_req;
    cbus_resp_t cbus_resp;

    // architectural view and expected main memory
    word_t cur [mem_words];
    word_t mem_exp [mem_words];
    logic  line_valid [2][num_sets];
    logic  line_dirty [2][num_sets];
    tag_t  line_tag [2][num_sets];
    logic  ref_lru [num_sets];

    dcache_top dcache_top_i (
        .clk       (clk),
        .resetn    (resetn),
        .dreq      (dreq),
        .cbus_resp (cbus_resp),
        .dresp     (dresp),
        .cbus_req  (cbus_req)
    );

    dcache_mem_model mem_model_i (
        .clk       (clk),
        .cbus_req  (cbus_req),
        .cbus_resp (cbus_resp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else fail_run($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    initial begin
        repeat (watch_cycles) @(posedge clk);
        fail_run("timeout, the cache stopped answering requests");
    end

    function automatic word_t fill_word(input int i);
        return word_t'(i) * 32'h9e3779b1 ^ 32'hc001d00d;
    endfunction

    function automatic word_t apply_strobe(input word_t old_w, input word_t new_w,
                                           input strobe_t strobe);
        word_t mask;
        mask = {{8{strobe[3]}}, {8{strobe[2]}}, {8{strobe[1]}}, {8{strobe[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int idx, input int off);
        return (tag << 13) | (idx << 6) | (off << 2);
    endfunction

    // starts and ends on a falling edge
    task automatic do_request(input logic unc, input logic [31:0] addr, input strobe_t strobe,
                              input word_t data, output word_t rdata, output int lat);
        dreq          = '0;
        dreq.valid    = 1'b1;
        dreq.uncached = unc;
        dreq.addr     = addr;
        dreq.strobe   = strobe;
        dreq.data     = data;
        while (!dresp.addr_ok) @(negedge clk);
        @(negedge clk);
        dreq = '0;
        lat  = 1;
        while (!dresp.data_ok) begin
            @(negedge clk);
            lat++;
        end
        rdata = dresp.data;
    endtask

    task automatic cached_access(input logic [31:0] addr, input strobe_t strobe,
                                 input word_t data);
        int    w;
        int    idx;
        int    way;
        int    base;
        int    rb0;
        int    wb0;
        int    lg0;
        int    lat;
        logic  hit;
        logic  evict;
        tag_t  tag;
        word_t rdata;
        w   = addr[15:2];
        idx = addr[12:6];
        tag = addr[31:13];
        hit = 1'b0;
        way = 0;
        for (int k = 0; k < 2; k++) begin
            if (line_valid[k][idx] && line_tag[k][idx] == tag) begin
                hit = 1'b1;
                way = k;
            end
        end
        rb0 = mem_model_i.read_bursts;
        wb0 = mem_model_i.write_bursts;
        lg0 = mem_model_i.log_count;
        do_request(1'b0, addr, strobe, data, rdata, lat);
        if (hit) begin
            check_value("hit latency", lat, 1);
            check_value("read_bursts", mem_model_i.read_bursts, rb0);
            check_value("write_bursts", mem_model_i.write_bursts, wb0);
        end else begin
            way   = ref_lru[idx];
            evict = line_valid[way][idx] && line_dirty[way][idx];
            base  = (int'(line_tag[way][idx]) << 11) | (idx << 4);
            if (evict) begin
                for (int o = 0; o < 16; o++) begin
                    mem_exp[base + o] = cur[base + o];
                end
            end
            check_value("read_bursts", mem_model_i.read_bursts, rb0 + 1);
            check_value("write_bursts", mem_model_i.write_bursts, wb0 + int'(evict));
            check_value("log_count", mem_model_i.log_count, lg0 + 16 * int'(evict));
            for (int i = lg0; i < mem_model_i.log_count; i++) begin
                check_value("writeback line", mem_model_i.log_addr[i] >> 4, base >> 4);
                check_value("writeback data", mem_model_i.log_data[i],
                            mem_exp[mem_model_i.log_addr[i]]);
            end
            line_valid[way][idx] = 1'b1;
            line_dirty[way][idx] = 1'b0;
            line_tag[way][idx]   = tag;
        end
        ref_lru[idx] = (way == 0);
        if (|strobe) begin
            line_dirty[way][idx] = 1'b1;
            cur[w] = apply_strobe(cur[w], data, strobe);
        end else begin
            check_value("dresp.data", rdata, cur[w]);
        end
    endtask

    task automatic uncached_access(input logic [31:0] addr, input strobe_t strobe,
                                   input word_t data);
        int    w;
        int    sr0;
        int    sw0;
        int    rb0;
        int    lat;
        word_t rdata;
        w   = addr[15:2];
        sr0 = mem_model_i.single_reads;
        sw0 = mem_model_i.single_writes;
        rb0 = mem_model_i.read_bursts;
        do_request(1'b1, addr, strobe, data, rdata, lat);
        check_value("read_bursts", mem_model_i.read_bursts, rb0);
        if (|strobe) begin
            check_value("single_writes", mem_model_i.single_writes, sw0 + 1);
            check_value("cbus_req.addr", mem_model_i.last_single_addr, w);
            check_value("cbus_req.strobe", mem_model_i.last_single_strobe, strobe);
            check_value("cbus_req.data", mem_model_i.last_single_data, data);
            cur[w]     = apply_strobe(cur[w], data, strobe);
            mem_exp[w] = apply_strobe(mem_exp[w], data, strobe);
        end else begin
            check_value("single_reads", mem_model_i.single_reads, sr0 + 1);
            check_value("dresp.data", rdata, mem_exp[w]);
        end
    endtask

    // line must already be cached in the model
    task automatic hit_stream(input int tag, input int idx, input int count);
        word_t expect_q[$];
        int    rb0;
        int    w;
        rb0 = mem_model_i.read_bursts;
        for (int i = 0; i <= count; i++) begin
            if (i > 0) begin
                check_value("dresp.data_ok", dresp.data_ok, 1);
                check_value("dresp.data", dresp.data, expect_q.pop_front());
            end
            dreq = '0;
            if (i < count) begin
                check_value("dresp.addr_ok", dresp.addr_ok, 1);
                w          = (tag << 11) | (idx << 4) | i;
                dreq.valid = 1'b1;
                dreq.addr  = make_addr(tag, idx, i);
                expect_q.push_back(cur[w]);
            end
            @(negedge clk);
        end
        check_value("read_bursts", mem_model_i.read_bursts, rb0);
        ref_lru[idx] = line_valid[0][idx] && line_tag[0][idx] == tag_t'(tag);
    endtask

    initial begin
        logic    ready_seen;
        strobe_t strobe;
        resetn = 1'b1;
        dreq   = '0;
        void'($urandom(73));
        for (int i = 0; i < mem_words; i++) begin
            cur[i]             = fill_word(i);
            mem_exp[i]         = fill_word(i);
            mem_model_i.mem[i] = fill_word(i);
        end
        for (int s = 0; s < num_sets; s++) begin
            ref_lru[s] = 1'b0;
            for (int k = 0; k < 2; k++) begin
                line_valid[k][s] = 1'b0;
                line_dirty[k][s] = 1'b0;
                line_tag[k][s]   = '0;
            end
        end
        repeat (8) @(negedge clk);
        resetn     = 1'b0;
        ready_seen = 1'b0;
        for (int c = 0; c < 140 && !ready_seen; c++) begin
            @(negedge clk);
            check_value("cbus_req.valid", cbus_req.valid, 0);
            check_value("dresp.data_ok", dresp.data_ok, 0);
            ready_seen = dresp.addr_ok;
        end
        assert (ready_seen)
        else fail_run("addr_ok did not rise within 140 cycles after reset");

        // read miss followed by a hit in the same line
        cached_access(make_addr(1, 5, 3), 4'b0000, '0);
        cached_access(make_addr(1, 5, 7), 4'b0000, '0);
        // write hit merges strobed bytes
        cached_access(make_addr(1, 5, 3), 4'b0101, 32'hdeadbeef);
        cached_access(make_addr(1, 5, 3), 4'b0000, '0);
        // three lines in set 9 with two of them dirty
        cached_access(make_addr(1, 9, 2), 4'b1111, 32'h11223344);
        cached_access(make_addr(2, 9, 12), 4'b0011, 32'h5566aabb);
        cached_access(make_addr(1, 9, 0), 4'b0000, '0);
        cached_access(make_addr(3, 9, 6), 4'b0000, '0);
        cached_access(make_addr(2, 9, 12), 4'b0000, '0);
        // uncached write and read followed by a cached read that must miss
        uncached_access(make_addr(4, 20, 2), 4'b1100, 32'hcafe0123);
        uncached_access(make_addr(4, 20, 2), 4'b0000, '0);
        cached_access(make_addr(4, 20, 2), 4'b0000, '0);
        hit_stream(1, 5, 8);
        for (int n = 0; n < 24; n++) begin
            strobe = $urandom_range(1) ? strobe_t'($urandom_range(1, 15)) : 4'b0000;
            cached_access(make_addr($urandom_range(0, 3), $urandom_range(1) ? 9 : 30,
                                    $urandom_range(0, 15)), strobe, $urandom);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dcache.f ====
design/dcache_pkg.sv
design/dcache_beat_counter.sv
design/dcache_data_array.sv
design/dcache_tag_store.sv
design/dcache_miss_ctrl.sv
design/dcache_top.sv
test/dcache_mem_model.sv
test/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - files:
      - design/dcache_pkg.sv
      - design/dcache_beat_counter.sv
      - design/dcache_data_array.sv
      - design/dcache_tag_store.sv
      - design/dcache_miss_ctrl.sv
      - design/dcache_top.sv
  - target: test
    files:
      - test/dcache_mem_model.sv
      - test/dcache_tb.sv
